// ==== ad9361_settings.svh ====
// sample width, half width, words per frame and reset stretch depth macros
`ifndef AD9361_SETTINGS_SVH
`define AD9361_SETTINGS_SVH

////////////////////////////////////////
// port format
////////////////////////////////////////

// bits in one i or q sample
`define AD_SAMPLE_W 12

// bits of a sample carried per bus word
`define AD_HALF_W 6

// bus words per frame (i0/q0 hi, lo, i1/q1 hi, lo)
`define AD_WORDS 4

////////////////////////////////////////
// reset
////////////////////////////////////////

// edges the internal reset trails lock
`define AD_RST_STAGES 3

`endif

// ==== ad9361_pkg.sv ====
// sample, half, bus word and frame step types plus the receive alignment state
`include "ad9361_settings.svh"

package ad9361_pkg;

  ////////////////////////////////////////
  // datapath words
  ////////////////////////////////////////

  // one i or q sample
  typedef logic [`AD_SAMPLE_W-1:0] sample_t;

  // upper or lower half of a sample
  typedef logic [`AD_HALF_W-1:0] half_t;

  // one word on the data bus
  // i half sits in the upper bits, q half below
  typedef logic [2*`AD_HALF_W-1:0] bus_word_t;

  ////////////////////////////////////////
  // framing
  ////////////////////////////////////////

  // word position within a frame
  // 0 and 1 belong to channel 0, 2 and 3 to channel 1
  typedef logic [$clog2(`AD_WORDS)-1:0] step_t;

  // deframer alignment
  // hunt waits for a strobe rise, locked tracks the 1 1 0 0 pattern
  typedef enum logic {
    HUNT,
    LOCKED
  } rx_state_t;

endpackage

// ==== tx_framer.sv ====
// transmit frame holding register, step counter and bus word multiplexer
`include "ad9361_settings.svh"

module tx_framer (
  input  logic                  d_clk,
  input  logic                  d_rst,
  // frame in
  input  logic                  tx_valid,
  output logic                  tx_ready,
  input  ad9361_pkg::sample_t   tx_i0,
  input  ad9361_pkg::sample_t   tx_q0,
  input  ad9361_pkg::sample_t   tx_i1,
  input  ad9361_pkg::sample_t   tx_q1,
  // bus out
  output logic                  tx_frame,
  output ad9361_pkg::bus_word_t tx_data
);

  import ad9361_pkg::*;

  localparam step_t last_step = step_t'(`AD_WORDS - 1);

  step_t   step;
  step_t   step_nxt;
  logic    take;
  sample_t hold_i0;
  sample_t hold_q0;
  sample_t hold_i1;
  sample_t hold_q1;
  sample_t sel_i0;
  sample_t sel_q0;
  sample_t sel_i1;
  sample_t sel_q1;

  // build one bus word for a given step
  function automatic bus_word_t pick_word(input step_t s, input sample_t i0,
                                          input sample_t q0, input sample_t i1,
                                          input sample_t q1);
    bus_word_t w;
    case (s)
      step_t'(0): w = {i0[`AD_SAMPLE_W-1 -: `AD_HALF_W], q0[`AD_SAMPLE_W-1 -: `AD_HALF_W]};
      step_t'(1): w = {i0[`AD_HALF_W-1:0], q0[`AD_HALF_W-1:0]};
      step_t'(2): w = {i1[`AD_SAMPLE_W-1 -: `AD_HALF_W], q1[`AD_SAMPLE_W-1 -: `AD_HALF_W]};
      default:    w = {i1[`AD_HALF_W-1:0], q1[`AD_HALF_W-1:0]};
    endcase
    return w;
  endfunction

  ////////////////////////////////////////
  // pacing
  ////////////////////////////////////////

  // ready while the last word of a frame is on the bus
  assign tx_ready = (step == last_step);
  assign take     = tx_ready & tx_valid;
  assign step_nxt = step + step_t'(1);

  // frame for the coming words
  // new frame on a transfer, zeros if none offered, else the held one
  always_comb begin
    if (take) begin
      sel_i0 = tx_i0;
      sel_q0 = tx_q0;
      sel_i1 = tx_i1;
      sel_q1 = tx_q1;
    end else if (tx_ready) begin
      sel_i0 = '0;
      sel_q0 = '0;
      sel_i1 = '0;
      sel_q1 = '0;
    end else begin
      sel_i0 = hold_i0;
      sel_q0 = hold_q0;
      sel_i1 = hold_i1;
      sel_q1 = hold_q1;
    end
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      // one short of the last word
      // first edge out of reset opens a ready cycle
      step     <= step_t'(`AD_WORDS - 2);
      hold_i0  <= '0;
      hold_q0  <= '0;
      hold_i1  <= '0;
      hold_q1  <= '0;
      tx_frame <= 1'b0;
      tx_data  <= '0;
    end else begin
      step <= step_nxt;
      if (tx_ready) begin
        hold_i0 <= sel_i0;
        hold_q0 <= sel_q0;
        hold_i1 <= sel_i1;
        hold_q1 <= sel_q1;
      end
      // strobe high for channel 0 words
      tx_frame <= (step_nxt < step_t'(`AD_WORDS / 2));
      tx_data  <= pick_word(step_nxt, sel_i0, sel_q0, sel_i1, sel_q1);
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // each ready cycle closes a 1 1 0 0 strobe run with no ready inside it
  frame_cadence: assert property (
    @(posedge d_clk) disable iff (d_rst)
    (tx_ready && !$past(d_rst, 4)) |->
      (!tx_frame && !$past(tx_frame) && $past(tx_frame, 2) && $past(tx_frame, 3) &&
       !$past(tx_ready) && !$past(tx_ready, 2) && !$past(tx_ready, 3))
  );

endmodule

// ==== rx_deframer.sv ====
// receive strobe aligner, sample assembler, output register and error flags
`include "ad9361_settings.svh"

module rx_deframer (
  input  logic                  d_clk,
  input  logic                  d_rst,
  // bus in
  input  logic                  rx_frame,
  input  ad9361_pkg::bus_word_t rx_data,
  // frame out
  output logic                  rx_valid,
  input  logic                  rx_ready,
  output ad9361_pkg::sample_t   rx_i0,
  output ad9361_pkg::sample_t   rx_q0,
  output ad9361_pkg::sample_t   rx_i1,
  output ad9361_pkg::sample_t   rx_q1,
  // sticky status
  output logic                  rx_overflow,
  output logic                  rx_frame_err
);

  import ad9361_pkg::*;

  localparam step_t last_step = step_t'(`AD_WORDS - 1);

  rx_state_t state;
  step_t     step;
  step_t     eff_step;
  logic      frame_q;
  logic      rise;
  logic      expect_frame;
  logic      strobe_bad;
  logic      word_ok;
  logic      done;
  logic      load;
  half_t     word_i;
  half_t     word_q;
  sample_t   asm_i0;
  sample_t   asm_q0;
  half_t     asm_i1_hi;
  half_t     asm_q1_hi;

  ////////////////////////////////////////
  // alignment
  ////////////////////////////////////////

  // split the bus word
  assign word_i = rx_data[2*`AD_HALF_W-1 -: `AD_HALF_W];
  assign word_q = rx_data[`AD_HALF_W-1:0];

  // strobe low then high marks word 0
  assign rise = rx_frame & ~frame_q;

  // 1 1 0 0 over the four steps
  assign expect_frame = (step < step_t'(`AD_WORDS / 2));

  // a rise always restarts the frame
  assign eff_step = rise ? step_t'(0) : step;

  always_comb begin
    strobe_bad = 1'b0;
    if (state == LOCKED) begin
      // rise is only legal where word 0 is due
      if (rise) begin
        strobe_bad = (step != step_t'(0));
      end else begin
        strobe_bad = (rx_frame != expect_frame);
      end
    end
  end

  // words that count toward a frame
  assign word_ok = rise | ((state == LOCKED) & ~strobe_bad);
  assign done    = word_ok & (eff_step == last_step);

  // take the new frame unless the held one is stuck
  assign load = done & (~rx_valid | rx_ready);

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      state        <= HUNT;
      step         <= '0;
      // starts high
      // a strobe already up at release is no edge
      frame_q      <= 1'b1;
      rx_valid     <= 1'b0;
      rx_overflow  <= 1'b0;
      rx_frame_err <= 1'b0;
    end else begin
      frame_q <= rx_frame;
      if (rise) begin
        state <= LOCKED;
      end else if (strobe_bad) begin
        // partial frame is abandoned
        state <= HUNT;
      end
      if (word_ok) begin
        step <= eff_step + step_t'(1);
      end
      if (strobe_bad) begin
        rx_frame_err <= 1'b1;
      end
      // completed frame with nowhere to go
      if (done && !load) begin
        rx_overflow <= 1'b1;
      end
      if (load) begin
        rx_valid <= 1'b1;
      end else if (rx_ready) begin
        rx_valid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // assembly and output
  ////////////////////////////////////////

  always_ff @(posedge d_clk) begin
    if (word_ok) begin
      case (eff_step)
        step_t'(0): begin
          asm_i0[`AD_SAMPLE_W-1 -: `AD_HALF_W] <= word_i;
          asm_q0[`AD_SAMPLE_W-1 -: `AD_HALF_W] <= word_q;
        end
        step_t'(1): begin
          asm_i0[`AD_HALF_W-1:0] <= word_i;
          asm_q0[`AD_HALF_W-1:0] <= word_q;
        end
        step_t'(2): begin
          asm_i1_hi <= word_i;
          asm_q1_hi <= word_q;
        end
        // last word goes straight to the output
        default: begin
        end
      endcase
    end
    if (load) begin
      rx_i0 <= asm_i0;
      rx_q0 <= asm_q0;
      rx_i1 <= {asm_i1_hi, word_i};
      rx_q1 <= {asm_q1_hi, word_q};
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // valid only drops after a transfer
  hold_valid: assert property (
    @(posedge d_clk) disable iff (d_rst)
    (rx_valid && !rx_ready) |=> rx_valid
  );

  // stalled frame stays put, a late frame cannot overwrite it
  hold_data: assert property (
    @(posedge d_clk) disable iff (d_rst)
    (rx_valid && !rx_ready) |=>
      ($stable(rx_i0) && $stable(rx_q0) && $stable(rx_i1) && $stable(rx_q1))
  );

endmodule

// ==== ad9361_lvds_if.sv ====
// transceiver port top level with lock reset stretcher, transmit framer and receive deframer
`include "ad9361_settings.svh"

module ad9361_lvds_if (
  input  logic                  d_clk,
  input  logic                  lock,
  // transmit frame in
  input  logic                  tx_valid,
  output logic                  tx_ready,
  input  ad9361_pkg::sample_t   tx_i0,
  input  ad9361_pkg::sample_t   tx_q0,
  input  ad9361_pkg::sample_t   tx_i1,
  input  ad9361_pkg::sample_t   tx_q1,
  // transmit pins
  output logic                  tx_frame,
  output ad9361_pkg::bus_word_t tx_data,
  // receive pins
  input  logic                  rx_frame,
  input  ad9361_pkg::bus_word_t rx_data,
  // receive frame out
  output logic                  rx_valid,
  input  logic                  rx_ready,
  output ad9361_pkg::sample_t   rx_i0,
  output ad9361_pkg::sample_t   rx_q0,
  output ad9361_pkg::sample_t   rx_i1,
  output ad9361_pkg::sample_t   rx_q1,
  // status
  output logic                  rx_overflow,
  output logic                  rx_frame_err
);

  logic [`AD_RST_STAGES-1:0] n_lock_sh;
  logic                      d_rst;

  ////////////////////////////////////////
  // reset stretcher
  ////////////////////////////////////////

  // lock low fills the chain with ones
  // after lock rises zeros walk in, one stage per edge
  always_ff @(posedge d_clk or negedge lock) begin
    if (!lock) begin
      n_lock_sh <= '1;
    end else begin
      n_lock_sh <= n_lock_sh >> 1;
    end
  end

  assign d_rst = n_lock_sh[0];

  // release needs three edges of steady lock
  rst_stretch: assert property (
    @(posedge d_clk)
    $fell(d_rst) |-> (lock && $past(lock) && $past(lock, 2) && $past(lock, 3))
  );

  ////////////////////////////////////////
  // datapaths
  ////////////////////////////////////////

  tx_framer tx0 (
    .d_clk    (d_clk),
    .d_rst    (d_rst),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_i0    (tx_i0),
    .tx_q0    (tx_q0),
    .tx_i1    (tx_i1),
    .tx_q1    (tx_q1),
    .tx_frame (tx_frame),
    .tx_data  (tx_data)
  );

  rx_deframer rx0 (
    .d_clk        (d_clk),
    .d_rst        (d_rst),
    .rx_frame     (rx_frame),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .rx_i0        (rx_i0),
    .rx_q0        (rx_q0),
    .rx_i1        (rx_i1),
    .rx_q1        (rx_q1),
    .rx_overflow  (rx_overflow),
    .rx_frame_err (rx_frame_err)
  );

endmodule

// ==== tb_clock_gen.sv ====
// testbench clock and lock source, period 40, lock low for the first 8 cycles
module tb_clock_gen (
  output logic d_clk,
  output logic lock
);

  // free running clock
  initial begin
    d_clk = 1'b0;
    forever #20 d_clk = ~d_clk;
  end

  // lock comes up after 8 rising edges
  initial begin
    lock = 1'b0;
    repeat (8) @(posedge d_clk);
    lock <= 1'b1;
  end

endmodule

// ==== tb_ad9361_lvds_if.sv ====
// testbench with loopback mux, random stimulus, frame reference model, compare tasks, timeout
`include "ad9361_settings.svh"

module tb_ad9361_lvds_if;

  import ad9361_pkg::*;

  typedef logic [`AD_WORDS-1:0][2*`AD_HALF_W-1:0] frame_words_t;

  // loopback frames per phase, plus the driven ones
  localparam int frames_fixed_ready  = 200;
  localparam int frames_random_ready = 100;
  localparam int frames_driven       = 5;
  localparam int num_frames  = frames_fixed_ready + frames_random_ready + frames_driven;
  localparam int cycle_limit = num_frames * `AD_WORDS + 200;
  localparam int loop_frames = frames_fixed_ready + frames_random_ready;

  logic      d_clk;
  logic      lock;
  logic      tx_valid = 1'b0;
  logic      tx_ready;
  sample_t   tx_i0 = '0;
  sample_t   tx_q0 = '0;
  sample_t   tx_i1 = '0;
  sample_t   tx_q1 = '0;
  logic      tx_frame;
  bus_word_t tx_data;
  logic      rx_frame;
  bus_word_t rx_data;
  logic      rx_valid;
  logic      rx_ready = 1'b1;
  sample_t   rx_i0;
  sample_t   rx_q0;
  sample_t   rx_i1;
  sample_t   rx_q1;
  logic      rx_overflow;
  logic      rx_frame_err;

  // loopback select and directly driven receive pins
  logic      loop_en = 1'b1;
  logic      rx_frame_drv = 1'b0;
  bus_word_t rx_data_drv = '0;

  // control from the main sequence
  logic       model_on = 1'b1;
  logic       drive_go = 1'b0;
  logic [1:0] ready_mode = 2'd0;

  logic [31:0] rng = 32'h96eff10f;
  logic [31:0] drv_rng;
  int          stall_cnt = 0;
  int          cycle_cnt = 0;
  int          tx_frames = 0;
  int          rx_count = 0;

  // expected transmit words and receive frames
  bus_word_t exp_word_q[$];
  logic      exp_strobe_q[$];
  sample_t   exp_i0_q[$];
  sample_t   exp_q0_q[$];
  sample_t   exp_i1_q[$];
  sample_t   exp_q1_q[$];
  // words for the directly driven receive pins
  bus_word_t drv_word_q[$];
  logic      drv_strobe_q[$];

  tb_clock_gen clk0 (
    .d_clk (d_clk),
    .lock  (lock)
  );

  ad9361_lvds_if dut0 (
    .d_clk        (d_clk),
    .lock         (lock),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .tx_i0        (tx_i0),
    .tx_q0        (tx_q0),
    .tx_i1        (tx_i1),
    .tx_q1        (tx_q1),
    .tx_frame     (tx_frame),
    .tx_data      (tx_data),
    .rx_frame     (rx_frame),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .rx_i0        (rx_i0),
    .rx_q0        (rx_q0),
    .rx_i1        (rx_i1),
    .rx_q1        (rx_q1),
    .rx_overflow  (rx_overflow),
    .rx_frame_err (rx_frame_err)
  );

  assign rx_frame = loop_en ? tx_frame : rx_frame_drv;
  assign rx_data  = loop_en ? tx_data : rx_data_drv;

  ////////////////////////////////////////
  // reference and helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // hi halves first, then lo halves, channel 0 then channel 1
  function automatic frame_words_t pack_frame(input sample_t i0, input sample_t q0,
                                              input sample_t i1, input sample_t q1);
    frame_words_t w;
    w[0] = {i0[`AD_SAMPLE_W-1 -: `AD_HALF_W], q0[`AD_SAMPLE_W-1 -: `AD_HALF_W]};
    w[1] = {i0[`AD_HALF_W-1:0], q0[`AD_HALF_W-1:0]};
    w[2] = {i1[`AD_SAMPLE_W-1 -: `AD_HALF_W], q1[`AD_SAMPLE_W-1 -: `AD_HALF_W]};
    w[3] = {i1[`AD_HALF_W-1:0], q1[`AD_HALF_W-1:0]};
    return w;
  endfunction

  task automatic fail_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  // outputs that stay quiet through reset
  task automatic check_idle_outputs();
    check_flag("rx_valid", 1'b0, rx_valid);
    check_flag("rx_overflow", 1'b0, rx_overflow);
    check_flag("rx_frame_err", 1'b0, rx_frame_err);
    check_flag("tx_frame", 1'b0, tx_frame);
    check_word("tx_data", '0, tx_data);
  endtask

  // one frame onto the driven pins, optionally with a strobe high in word 2
  task automatic queue_drive_frame(input sample_t i0, input sample_t q0, input sample_t i1,
                                   input sample_t q1, input logic bad_strobe);
    frame_words_t w;
    int k;
    w = pack_frame(i0, q0, i1, q1);
    for (k = 0; k < `AD_WORDS; k++) begin
      drv_word_q.push_back(w[k]);
      drv_strobe_q.push_back((k < `AD_WORDS / 2) || (bad_strobe && k == 2));
    end
  endtask

  task automatic push_expected(input sample_t i0, input sample_t q0, input sample_t i1,
                               input sample_t q1);
    exp_i0_q.push_back(i0);
    exp_q0_q.push_back(q0);
    exp_i1_q.push_back(i1);
    exp_q1_q.push_back(q1);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  always @(posedge d_clk) begin : drive_inputs
    logic [31:0] r1;
    logic [31:0] r2;
    r1  = xorshift32(rng);
    r2  = xorshift32(r1);
    rng = r2;
    // about one frame in four is not offered
    tx_valid <= (r1[1:0] != 2'b00);
    tx_i0    <= r1[31:20];
    tx_q0    <= r1[19:8];
    tx_i1    <= r2[27:16];
    tx_q1    <= r2[13:2];
    // ready: held high, random with at most two low cycles, or held low
    if (ready_mode == 2'd1) begin
      if (stall_cnt >= 2 || r2[30]) begin
        rx_ready  <= 1'b1;
        stall_cnt <= 0;
      end else begin
        rx_ready  <= 1'b0;
        stall_cnt <= stall_cnt + 1;
      end
    end else begin
      rx_ready <= (ready_mode == 2'd0);
    end
    // switch pins over to the driven words
    if (drive_go) begin
      loop_en <= 1'b0;
      if (drv_word_q.size() > 0) begin
        rx_data_drv  <= drv_word_q.pop_front();
        rx_frame_drv <= drv_strobe_q.pop_front();
      end else begin
        rx_data_drv  <= '0;
        rx_frame_drv <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // model and compare
  ////////////////////////////////////////

  always @(negedge d_clk) begin : compare_outputs
    frame_words_t words;
    int           k;
    logic         stall_seen;
    sample_t      held_i0;
    sample_t      held_q0;
    sample_t      held_i1;
    sample_t      held_q1;
    // words from earlier transfers come out in order
    if (exp_word_q.size() > 0) begin
      check_word("tx_data", exp_word_q.pop_front(), tx_data);
      check_flag("tx_frame", exp_strobe_q.pop_front(), tx_frame);
    end
    // next edge takes the offered frame, or zeros
    if (tx_ready) begin
      if (tx_valid) begin
        words = pack_frame(tx_i0, tx_q0, tx_i1, tx_q1);
      end else begin
        words = pack_frame('0, '0, '0, '0);
      end
      for (k = 0; k < `AD_WORDS; k++) begin
        exp_word_q.push_back(words[k]);
        exp_strobe_q.push_back(k < `AD_WORDS / 2);
      end
      if (model_on) begin
        if (tx_valid) begin
          push_expected(tx_i0, tx_q0, tx_i1, tx_q1);
        end else begin
          push_expected('0, '0, '0, '0);
        end
        tx_frames++;
      end
    end
    // stalled output must not move
    if (stall_seen) begin
      check_flag("rx_valid", 1'b1, rx_valid);
      check_sample("rx_i0", held_i0, rx_i0);
      check_sample("rx_q0", held_q0, rx_q0);
      check_sample("rx_i1", held_i1, rx_i1);
      check_sample("rx_q1", held_q1, rx_q1);
    end
    if (rx_valid && rx_ready) begin
      if (exp_i0_q.size() == 0) begin
        $display("a receive frame came out while none was expected");
        fail_run();
      end
      check_sample("rx_i0", exp_i0_q.pop_front(), rx_i0);
      check_sample("rx_q0", exp_q0_q.pop_front(), rx_q0);
      check_sample("rx_i1", exp_i1_q.pop_front(), rx_i1);
      check_sample("rx_q1", exp_q1_q.pop_front(), rx_q1);
      rx_count++;
    end
    stall_seen = rx_valid && !rx_ready;
    held_i0    = rx_i0;
    held_q0    = rx_q0;
    held_i1    = rx_i1;
    held_q1    = rx_q1;
  end

  // run limit from the frame count
  always @(posedge d_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      fail_run();
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : run_tests
    int      n;
    sample_t f1_i0;
    drv_rng = xorshift32(32'h96eff10f ^ 32'h5a5a5a5a);
    // reset, lock low
    do begin
      @(negedge d_clk);
      check_flag("tx_ready", 1'b0, tx_ready);
      check_idle_outputs();
    end while (!lock);
    // stretched reset, first ready after release
    n = 0;
    do begin
      @(negedge d_clk);
      check_idle_outputs();
      n++;
      if (n > 2 * `AD_RST_STAGES + 2) begin
        $display("tx_ready did not come up after lock rose");
        fail_run();
      end
    end while (!tx_ready);
    // release after the stretch, then one edge to open the ready cycle
    if (n != `AD_RST_STAGES + 1) begin
      $display("tx_ready came up %0d cycles after lock rose instead of %0d", n,
               `AD_RST_STAGES + 1);
      fail_run();
    end

    // loopback, ready held high
    while (tx_frames < frames_fixed_ready) @(posedge d_clk);
    ready_mode <= 2'd1;
    // loopback, random ready
    while (tx_frames < loop_frames) @(posedge d_clk);
    @(negedge d_clk);
    check_flag("rx_overflow", 1'b0, rx_overflow);
    check_flag("rx_frame_err", 1'b0, rx_frame_err);

    // stop the model on a transfer edge
    do @(negedge d_clk); while (!tx_ready);
    @(posedge d_clk);
    model_on   <= 1'b0;
    ready_mode <= 2'd0;
    // driven frames: two for the overflow, one good, one broken, one good
    for (n = 0; n < frames_driven; n++) begin
      drv_rng = xorshift32(drv_rng);
      if (n == 0) begin
        f1_i0 = drv_rng[31:20];
      end
      queue_drive_frame(drv_rng[31:20], drv_rng[19:8], drv_rng[11:0], drv_rng[27:16], n == 3);
      if (n != 1 && n != 3) begin
        push_expected(drv_rng[31:20], drv_rng[19:8], drv_rng[11:0], drv_rng[27:16]);
      end
    end
    // hand over right after the last looped word 3
    repeat (3) @(posedge d_clk);
    drive_go <= 1'b1;

    // overflow with ready held low, once every looped frame is out
    while (rx_count < tx_frames) @(posedge d_clk);
    ready_mode <= 2'd2;
    do @(negedge d_clk); while (!rx_overflow);
    check_flag("rx_valid", 1'b1, rx_valid);
    check_sample("rx_i0", f1_i0, rx_i0);
    check_flag("rx_frame_err", 1'b0, rx_frame_err);
    @(posedge d_clk);
    ready_mode <= 2'd0;

    // strobe error, then a clean frame
    while (rx_count < tx_frames + 3) @(posedge d_clk);
    repeat (4) @(negedge d_clk);
    check_flag("rx_frame_err", 1'b1, rx_frame_err);
    check_flag("rx_overflow", 1'b1, rx_overflow);

    if (exp_i0_q.size() == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("expected receive frames were left over");
      fail_run();
    end
  end

endmodule

// ==== sim.f ====
+incdir+.
ad9361_pkg.sv
tx_framer.sv
rx_deframer.sv
ad9361_lvds_if.sv
tb_clock_gen.sv
tb_ad9361_lvds_if.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ad9361_lvds_if -f sim.f -o tb_sim &&
  ./obj_dir/tb_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
  echo "simulation ok" ||
  { echo "simulation failed"; exit 1; }

exit 0
